/* verilog/terminal_pkg.sv */
// shared definitions for the terminal routing core
// terminal addresses, control register map and transfer status codes
// memory port instruction type and field widths
package terminal_pkg;

   typedef logic [15:0] term_addr_t;
   typedef logic [31:0] word_t;      // data word or word address
   typedef logic [15:0] status_t;

   // internal terminals, anything else goes to the project
   localparam term_addr_t TERM_DUMMY     = 16'h00ff;
   localparam term_addr_t TERM_DRAM      = 16'h0800;
   localparam term_addr_t TERM_DRAM_CTRL = 16'h0801;

   // odd word addresses read this, even ones read the inverse
   localparam word_t DUMMY_PATTERN = 32'hbbaa9988;

   // control terminal register map
   localparam word_t CTRL_REG_STATUS = 32'h0000_0000; // bit0 calib_done, bit1 mem_reset
   localparam word_t CTRL_REG_RESET  = 32'h0000_0001;
   localparam word_t CTRL_REG_BURST  = 32'h0000_0002; // burst length in words

   localparam status_t STATUS_OK        = 16'h0000;
   localparam status_t STATUS_NOT_READY = 16'h0001;

   // controller port command encoding
   typedef enum logic [2:0] {
      MEM_WRITE = 3'b000,
      MEM_READ  = 3'b001
   } mem_instr_t;

   localparam int BL_W        = 6;  // burst length fields
   localparam int BYTE_ADDR_W = 30; // memory byte addresses

endpackage

/* verilog/term_if.sv */
`timescale 1ns/10ps
// host bus slice between the router and one internal terminal
// the decoded terminal address stays in the router
interface term_if import terminal_pkg::*; ();

   word_t   reg_addr;
   word_t   len;
   logic    read_mode;
   logic    read;
   logic    write_mode;
   logic    write;
   word_t   reg_datai;
   logic    read_rdy;
   logic    write_rdy;
   word_t   reg_datao;
   status_t transfer_status;

   modport router (
      output reg_addr, len, read_mode, read, write_mode, write, reg_datai,
      input  read_rdy, write_rdy, reg_datao, transfer_status
   );

   modport terminal (
      input  reg_addr, len, read_mode, read, write_mode, write, reg_datai,
      output read_rdy, write_rdy, reg_datao, transfer_status
   );

endinterface

/* verilog/terminal_router.sv */
`timescale 1ns/10ps
// terminal address decode and strobe steering
// response mux back to the host and the built-in dummy terminal
module terminal_router import terminal_pkg::*; (
   input  logic       ifclk,
   input  logic       arst_n,
   input  term_addr_t term_addr,
   input  word_t      reg_addr,
   input  word_t      len,
   input  logic       read_mode,
   input  logic       read,
   input  logic       write_mode,
   input  logic       write,
   input  word_t      reg_datai,
   output logic       read_rdy,
   output logic       write_rdy,
   output word_t      reg_datao,
   output status_t    transfer_status,
   output logic       pt_read_mode,
   output logic       pt_read,
   output logic       pt_write_mode,
   output logic       pt_write,
   input  logic       pt_read_rdy,
   input  logic       pt_write_rdy,
   input  word_t      pt_reg_datao,
   input  status_t    pt_transfer_status,
   term_if.router     ctrl_bus,
   term_if.router     dram_bus
);

   localparam logic [1:0] SEL_PT    = 2'd0;
   localparam logic [1:0] SEL_DUMMY = 2'd1;
   localparam logic [1:0] SEL_CTRL  = 2'd2;
   localparam logic [1:0] SEL_DRAM  = 2'd3;

   logic [1:0] sel_now, sel_q, sel;
   logic       busy_q;
   logic       is_pt, is_ctrl, is_dram;

   always_comb begin
      case (term_addr)
         TERM_DUMMY:     sel_now = SEL_DUMMY;
         TERM_DRAM_CTRL: sel_now = SEL_CTRL;
         TERM_DRAM:      sel_now = SEL_DRAM;
         default:        sel_now = SEL_PT;
      endcase
   end

   // destination is held for the rest of a transfer once a mode is up
   always_ff @(posedge ifclk or negedge arst_n) begin
      if (!arst_n) begin
         busy_q <= 1'b0;
         sel_q  <= SEL_PT;
      end else begin
         busy_q <= read_mode | write_mode;
         if (read_mode | write_mode)
            sel_q <= sel;
      end
   end

   assign sel     = busy_q ? sel_q : sel_now;
   assign is_pt   = sel == SEL_PT;
   assign is_ctrl = sel == SEL_CTRL;
   assign is_dram = sel == SEL_DRAM;

   assign pt_read_mode  = is_pt & read_mode;
   assign pt_read       = is_pt & read;
   assign pt_write_mode = is_pt & write_mode;
   assign pt_write      = is_pt & write;

   assign ctrl_bus.reg_addr   = reg_addr;
   assign ctrl_bus.len        = len;
   assign ctrl_bus.reg_datai  = reg_datai;
   assign ctrl_bus.read_mode  = is_ctrl & read_mode;
   assign ctrl_bus.read       = is_ctrl & read;
   assign ctrl_bus.write_mode = is_ctrl & write_mode;
   assign ctrl_bus.write      = is_ctrl & write;

   assign dram_bus.reg_addr   = reg_addr;
   assign dram_bus.len        = len;
   assign dram_bus.reg_datai  = reg_datai;
   assign dram_bus.read_mode  = is_dram & read_mode;
   assign dram_bus.read       = is_dram & read;
   assign dram_bus.write_mode = is_dram & write_mode;
   assign dram_bus.write      = is_dram & write;

   always_comb begin
      case (sel)
         SEL_DUMMY: begin   // writes are simply dropped
            reg_datao       = reg_addr[0] ? DUMMY_PATTERN : ~DUMMY_PATTERN;
            read_rdy        = read_mode;
            write_rdy       = write_mode;
            transfer_status = STATUS_OK;
         end
         SEL_CTRL: begin
            reg_datao       = ctrl_bus.reg_datao;
            read_rdy        = ctrl_bus.read_rdy;
            write_rdy       = ctrl_bus.write_rdy;
            transfer_status = ctrl_bus.transfer_status;
         end
         SEL_DRAM: begin
            reg_datao       = dram_bus.reg_datao;
            read_rdy        = dram_bus.read_rdy;
            write_rdy       = dram_bus.write_rdy;
            transfer_status = dram_bus.transfer_status;
         end
         default: begin
            reg_datao       = pt_reg_datao;
            read_rdy        = pt_read_rdy;
            write_rdy       = pt_write_rdy;
            transfer_status = pt_transfer_status;
         end
      endcase
   end

endmodule

/* verilog/ctrl_terminal.sv */
`timescale 1ns/10ps
// memory control terminal
// status, reset and burst length registers, calib_done synchronizer
module ctrl_terminal import terminal_pkg::*; #(
   parameter int MAX_BURST     = 32,
   parameter int DEFAULT_BURST = 8
) (
   input  logic            ifclk,
   input  logic            arst_n,
   term_if.terminal        bus,
   input  logic            mem_calib_done,
   output logic            mem_reset,
   output logic [BL_W-1:0] burst_len,
   output logic            calib_done
);

   logic [1:0]      calib_sync;
   logic            reset_q;
   logic [BL_W-1:0] burst_q;
   logic [BL_W-1:0] burst_wr;

   // keep the burst inside 1..MAX_BURST
   always_comb begin
      if (bus.reg_datai == '0)
         burst_wr = BL_W'(1);
      else if (bus.reg_datai > word_t'(MAX_BURST))
         burst_wr = BL_W'(MAX_BURST);
      else
         burst_wr = bus.reg_datai[BL_W-1:0];
   end

   always_ff @(posedge ifclk or negedge arst_n) begin
      if (!arst_n) begin
         calib_sync <= 2'b00;
         reset_q    <= 1'b0;
         burst_q    <= BL_W'(DEFAULT_BURST);
      end else begin
         calib_sync <= {calib_sync[0], mem_calib_done};
         if (bus.write) begin
            if (bus.reg_addr == CTRL_REG_RESET)
               reset_q <= bus.reg_datai[0];
            if (bus.reg_addr == CTRL_REG_BURST)
               burst_q <= burst_wr;
         end
      end
   end

   assign calib_done = calib_sync[1];
   assign mem_reset  = reset_q;
   assign burst_len  = burst_q;

   // same word on every read, no address increment
   always_comb begin
      case (bus.reg_addr)
         CTRL_REG_STATUS: bus.reg_datao = word_t'({reset_q, calib_sync[1]});
         CTRL_REG_RESET:  bus.reg_datao = word_t'(reset_q);
         CTRL_REG_BURST:  bus.reg_datao = word_t'(burst_q);
         default:         bus.reg_datao = '0;
      endcase
   end

   assign bus.read_rdy        = bus.read_mode;
   assign bus.write_rdy       = bus.write_mode;
   assign bus.transfer_status = STATUS_OK;

endmodule

/* verilog/dram_terminal.sv */
`timescale 1ns/10ps
// DRAM bridge terminal
// host writes go straight into the write FIFO, a command closes each burst
// host reads are requested one burst at a time from the read FIFO
module dram_terminal import terminal_pkg::*; #(
   parameter int MAX_BURST = 32
) (
   input  logic                   ifclk,
   input  logic                   arst_n,
   term_if.terminal               bus,
   input  logic [BL_W-1:0]        burst_len,
   input  logic                   calib_done,
   output logic                   mem_cmd_en,
   output mem_instr_t             mem_cmd_instr,
   output logic [BL_W-1:0]        mem_cmd_bl,
   output logic [BYTE_ADDR_W-1:0] mem_cmd_byte_addr,
   input  logic                   mem_cmd_full,
   output logic                   mem_wr_en,
   output word_t                  mem_wr_data,
   output logic                   mem_rd_en,
   input  word_t                  mem_rd_data,
   input  logic                   mem_rd_empty
);

   localparam int CNT_W = $clog2(MAX_BURST + 1);

   logic             wmode_q, rmode_q;
   logic             cmd_pend;           // command register holds an unsent command
   logic [CNT_W-1:0] wr_cnt, cur_cnt, cnt_inc;
   logic [CNT_W-1:0] rd_out;             // words of the read burst not yet taken
   word_t            wr_addr, wr_base, cur_addr, cur_base;
   word_t            rd_addr, rd_left, rd_n;
   logic             write_ok, read_ok, wr_acc, rd_acc;
   logic             burst_done, wr_flush, wr_load, rd_load;

   function automatic logic [BYTE_ADDR_W-1:0] byte_addr(input word_t word_addr);
      return {word_addr[BYTE_ADDR_W-3:0], 2'b00};
   endfunction

   assign mem_cmd_en = cmd_pend & ~mem_cmd_full;

   // without calibration words are taken and dropped
   assign write_ok   = bus.write_mode & (~calib_done | ~cmd_pend | ~mem_cmd_full);
   assign wr_acc     = bus.write & write_ok & calib_done;
   assign cur_addr   = wmode_q ? wr_addr : bus.reg_addr; // first word can come with the mode
   assign cur_cnt    = wmode_q ? wr_cnt : '0;
   assign cur_base   = (cur_cnt == '0) ? cur_addr : wr_base;
   assign cnt_inc    = cur_cnt + 1'b1;
   assign burst_done = cnt_inc == CNT_W'(burst_len);
   assign wr_flush   = wmode_q & ~bus.write_mode & (wr_cnt != '0) & calib_done;
   assign wr_load    = (wr_acc & burst_done) | wr_flush;

   assign mem_wr_en   = wr_acc;
   assign mem_wr_data = bus.reg_datai;

   assign rd_n    = (rd_left < word_t'(burst_len)) ? rd_left : word_t'(burst_len);
   assign rd_load = rmode_q & bus.read_mode & calib_done & (rd_left != '0)
                    & (rd_out == '0) & ~cmd_pend & ~wr_load;
   assign read_ok = bus.read_mode & (~calib_done | (~mem_rd_empty & (rd_out != '0)));
   assign rd_acc  = bus.read & read_ok & calib_done;

   assign mem_rd_en = rd_acc;

   assign bus.read_rdy        = read_ok;
   assign bus.write_rdy       = write_ok;
   assign bus.reg_datao       = calib_done ? mem_rd_data : '0;
   assign bus.transfer_status = calib_done ? STATUS_OK : STATUS_NOT_READY;

   always_ff @(posedge ifclk or negedge arst_n) begin
      if (!arst_n) begin
         wmode_q  <= 1'b0;
         rmode_q  <= 1'b0;
         cmd_pend <= 1'b0;
         wr_cnt   <= '0;
         rd_out   <= '0;
      end else begin
         wmode_q <= bus.write_mode;
         rmode_q <= bus.read_mode;
         if (wr_load | rd_load)
            cmd_pend <= 1'b1;
         else if (mem_cmd_en)
            cmd_pend <= 1'b0;

         if (wr_acc)
            wr_cnt <= burst_done ? '0 : cnt_inc;
         else if (~wmode_q | wr_flush)
            wr_cnt <= '0;

         if (rd_load)
            rd_out <= CNT_W'(rd_n);
         else if (~rmode_q)
            rd_out <= '0;   // drop what an aborted read left behind
         else if (rd_acc)
            rd_out <= rd_out - 1'b1;
      end
   end

   // command fields and running addresses
   always_ff @(posedge ifclk) begin
      if (wr_load) begin
         mem_cmd_instr     <= MEM_WRITE;
         mem_cmd_bl        <= wr_flush ? BL_W'(wr_cnt - 1'b1) : BL_W'(cnt_inc - 1'b1);
         mem_cmd_byte_addr <= byte_addr(wr_flush ? wr_base : cur_base);
      end else if (rd_load) begin
         mem_cmd_instr     <= MEM_READ;
         mem_cmd_bl        <= BL_W'(rd_n - 1'b1);
         mem_cmd_byte_addr <= byte_addr(rd_addr);
      end

      if (wr_acc) begin
         wr_addr <= cur_addr + 1'b1;
         if (cur_cnt == '0)
            wr_base <= cur_addr;
      end else if (~wmode_q) begin
         wr_addr <= bus.reg_addr;
      end

      if (~rmode_q) begin
         rd_addr <= bus.reg_addr;
         rd_left <= bus.len;
      end else if (rd_load) begin
         rd_addr <= rd_addr + rd_n;
         rd_left <= rd_left - rd_n;
      end
   end

endmodule

/* verilog/host_terminal_hub.sv */
`timescale 1ns/10ps
// top level of the terminal routing core
// host bus in, project port and one memory controller port out
// router, control terminal and DRAM bridge joined by two term_if buses
module host_terminal_hub import terminal_pkg::*; #(
   parameter int MAX_BURST     = 32,
   parameter int DEFAULT_BURST = 8
) (
   input  logic                   ifclk,
   input  logic                   arst_n,

   // host bus
   input  term_addr_t             term_addr,
   input  word_t                  reg_addr,
   input  word_t                  len,
   input  logic                   read_mode,
   input  logic                   read,
   input  logic                   write_mode,
   input  logic                   write,
   input  word_t                  reg_datai,
   output logic                   read_rdy,
   output logic                   write_rdy,
   output word_t                  reg_datao,
   output status_t                transfer_status,

   // project terminal
   output logic                   pt_read_mode,
   output logic                   pt_read,
   output logic                   pt_write_mode,
   output logic                   pt_write,
   input  logic                   pt_read_rdy,
   input  logic                   pt_write_rdy,
   input  word_t                  pt_reg_datao,
   input  status_t                pt_transfer_status,

   // memory controller port
   output logic                   mem_cmd_en,
   output mem_instr_t             mem_cmd_instr,
   output logic [BL_W-1:0]        mem_cmd_bl,       // burst length minus one
   output logic [BYTE_ADDR_W-1:0] mem_cmd_byte_addr,
   input  logic                   mem_cmd_full,
   output logic                   mem_wr_en,
   output word_t                  mem_wr_data,
   output logic                   mem_rd_en,
   input  word_t                  mem_rd_data,
   input  logic                   mem_rd_empty,
   output logic                   mem_reset,
   input  logic                   mem_calib_done
);

   logic [BL_W-1:0] burst_len;
   logic            calib_done;    // synchronized in the control terminal

   term_if ctrl_bus ();
   term_if dram_bus ();

   terminal_router terminal_router_inst (
      .ifclk              (ifclk),
      .arst_n             (arst_n),
      .term_addr          (term_addr),
      .reg_addr           (reg_addr),
      .len                (len),
      .read_mode          (read_mode),
      .read               (read),
      .write_mode         (write_mode),
      .write              (write),
      .reg_datai          (reg_datai),
      .read_rdy           (read_rdy),
      .write_rdy          (write_rdy),
      .reg_datao          (reg_datao),
      .transfer_status    (transfer_status),
      .pt_read_mode       (pt_read_mode),
      .pt_read            (pt_read),
      .pt_write_mode      (pt_write_mode),
      .pt_write           (pt_write),
      .pt_read_rdy        (pt_read_rdy),
      .pt_write_rdy       (pt_write_rdy),
      .pt_reg_datao       (pt_reg_datao),
      .pt_transfer_status (pt_transfer_status),
      .ctrl_bus           (ctrl_bus.router),
      .dram_bus           (dram_bus.router)
   );

   ctrl_terminal #(
      .MAX_BURST     (MAX_BURST),
      .DEFAULT_BURST (DEFAULT_BURST)
   ) ctrl_terminal_inst (
      .ifclk          (ifclk),
      .arst_n         (arst_n),
      .bus            (ctrl_bus.terminal),
      .mem_calib_done (mem_calib_done),
      .mem_reset      (mem_reset),
      .burst_len      (burst_len),
      .calib_done     (calib_done)
   );

   dram_terminal #(
      .MAX_BURST (MAX_BURST)
   ) dram_terminal_inst (
      .ifclk             (ifclk),
      .arst_n            (arst_n),
      .bus               (dram_bus.terminal),
      .burst_len         (burst_len),
      .calib_done        (calib_done),
      .mem_cmd_en        (mem_cmd_en),
      .mem_cmd_instr     (mem_cmd_instr),
      .mem_cmd_bl        (mem_cmd_bl),
      .mem_cmd_byte_addr (mem_cmd_byte_addr),
      .mem_cmd_full      (mem_cmd_full),
      .mem_wr_en         (mem_wr_en),
      .mem_wr_data       (mem_wr_data),
      .mem_rd_en         (mem_rd_en),
      .mem_rd_data       (mem_rd_data),
      .mem_rd_empty      (mem_rd_empty)
   );

endmodule

/* testbench/mem_port_model.sv */
`timescale 1ns/10ps
// behavioral model of one memory controller port
// command intake, write and read FIFOs, word store by byte address
// random command back-pressure and read latency
module mem_port_model import terminal_pkg::*; (
   input  logic                   ifclk,
   input  logic                   arst_n,
   input  logic                   stress,       // random full flag and read delay
   input  logic                   mem_cmd_en,
   input  mem_instr_t             mem_cmd_instr,
   input  logic [BL_W-1:0]        mem_cmd_bl,
   input  logic [BYTE_ADDR_W-1:0] mem_cmd_byte_addr,
   output logic                   mem_cmd_full,
   input  logic                   mem_wr_en,
   input  word_t                  mem_wr_data,
   input  logic                   mem_rd_en,
   output word_t                  mem_rd_data,
   output logic                   mem_rd_empty
);

   integer                 seed = 32'he62c7dd2;
   word_t                  store [logic [BYTE_ADDR_W-1:0]];
   word_t                  wr_fifo [$];
   word_t                  rd_fifo [$];
   logic [BYTE_ADDR_W-1:0] rd_pend [$];   // read addresses not returned yet
   logic [BYTE_ADDR_W-1:0] a;
   logic                   full_next;

   initial begin
      mem_cmd_full = 1'b0;
      mem_rd_empty = 1'b1;
      mem_rd_data  = '1;
   end

   always begin
      @(posedge ifclk);
      if (!arst_n) begin
         wr_fifo.delete();
         rd_fifo.delete();
         rd_pend.delete();
      end else begin
         if (mem_wr_en)
            wr_fifo.push_back(mem_wr_data);
         if (mem_rd_en && rd_fifo.size() != 0)
            void'(rd_fifo.pop_front());
         if (mem_cmd_en && !mem_cmd_full) begin
            for (int i = 0; i <= int'(mem_cmd_bl); i++) begin
               a = mem_cmd_byte_addr + BYTE_ADDR_W'(4 * i);
               if (mem_cmd_instr == MEM_WRITE)
                  store[a] = wr_fifo.pop_front();
               else
                  rd_pend.push_back(a);
            end
         end
         // at most one read word comes back per cycle
         if (rd_pend.size() != 0 && (!stress || ($random(seed) % 3) == 0))
            rd_fifo.push_back(store[rd_pend.pop_front()]);
      end
      full_next = stress && (($random(seed) & 3) == 0);
      #1;
      mem_cmd_full = full_next;
      mem_rd_empty = rd_fifo.size() == 0;
      mem_rd_data  = mem_rd_empty ? '1 : rd_fifo[0];   // first word falls through, junk while empty
   end

endmodule

/* testbench/tb_host_terminal_hub.sv */
`timescale 1ns/10ps
// testbench for the terminal routing core
// host bus tasks, project responder, memory command monitor
// assertions on routing, commands and data, timeout
module tb_host_terminal_hub import terminal_pkg::*; ();

   localparam int         MAX_BURST     = 32;
   localparam int         DEFAULT_BURST = 8;
   localparam int         TEST_WORDS    = 127;   // host words over all tests
   localparam int         CYCLE_LIMIT   = TEST_WORDS * 40 + 2000;
   localparam term_addr_t TERM_PROJECT  = 16'h1234;

   logic ifclk, arst_n;
   term_addr_t term_addr;
   word_t reg_addr, len, reg_datai, reg_datao;
   logic read_mode, read, write_mode, write, read_rdy, write_rdy;
   status_t transfer_status;
   logic pt_read_mode, pt_read, pt_write_mode, pt_write, pt_read_rdy, pt_write_rdy;
   word_t pt_reg_datao;
   status_t pt_transfer_status;
   logic mem_cmd_en, mem_cmd_full, mem_wr_en, mem_rd_en, mem_rd_empty;
   logic mem_reset, mem_calib_done;
   mem_instr_t mem_cmd_instr;
   logic [BL_W-1:0] mem_cmd_bl;
   logic [BYTE_ADDR_W-1:0] mem_cmd_byte_addr;
   word_t mem_wr_data, mem_rd_data;

   logic stress, no_cal, pt_phase, to_pt;
   int cycles = 0;
   int pt_words = 0;
   int burst_set;
   word_t wbuf [64];
   word_t rbuf [64];
   status_t last_status;
   mem_instr_t log_instr [$];
   logic [BL_W-1:0] log_bl [$];
   logic [BYTE_ADDR_W-1:0] log_addr [$];

   host_terminal_hub #(
      .MAX_BURST     (MAX_BURST),
      .DEFAULT_BURST (DEFAULT_BURST)
   ) host_terminal_hub_inst (.*);

   mem_port_model mem_port_model_inst (.*);

   initial ifclk = 1'b0;
   always #50 ifclk = ~ifclk;

   // project responder, ready every other cycle
   always @(posedge ifclk or negedge arst_n) begin
      if (!arst_n)
         pt_phase <= 1'b0;
      else
         pt_phase <= ~pt_phase;
   end
   assign pt_read_rdy        = pt_read_mode & pt_phase;
   assign pt_write_rdy       = pt_write_mode & pt_phase;
   assign pt_reg_datao       = {16'hc0de, reg_addr[15:0]};
   assign pt_transfer_status = 16'h0042;
   assign to_pt = !(term_addr inside {TERM_DUMMY, TERM_DRAM, TERM_DRAM_CTRL});

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("TEST FAIL");
      $fatal(1);
   endtask

   // memory command log and cycle limit
   always @(posedge ifclk) begin
      if (mem_cmd_en && !mem_cmd_full) begin
         log_instr.push_back(mem_cmd_instr);
         log_bl.push_back(mem_cmd_bl);
         log_addr.push_back(mem_cmd_byte_addr);
      end
      if (pt_write && pt_write_rdy)
         pt_words = pt_words + 1;
      cycles = cycles + 1;
      if (cycles > CYCLE_LIMIT)
         abort_run($sformatf("timeout, run did not finish in %0d cycles", CYCLE_LIMIT));
   end

   assert property (@(posedge ifclk) disable iff (!arst_n) !(mem_cmd_en && mem_cmd_full))
      else abort_run("memory command raised while the command FIFO was full");
   assert property (@(posedge ifclk) disable iff (!arst_n)
         !(mem_cmd_en && mem_cmd_instr == MEM_READ && int'(mem_cmd_bl) >= burst_set))
      else abort_run("read command longer than the burst register");
   assert property (@(posedge ifclk) disable iff (!arst_n) !(no_cal && mem_cmd_en))
      else abort_run("memory command issued while not calibrated");
   assert property (@(posedge ifclk) disable iff (!arst_n)
         {pt_read_mode, pt_read, pt_write_mode, pt_write}
            == ({read_mode, read, write_mode, write} & {4{to_pt}}))
      else abort_run("project strobes do not follow the host strobes");
   assert property (@(posedge ifclk) disable iff (!arst_n)
         to_pt |-> (read_rdy == pt_read_rdy && write_rdy == pt_write_rdy))
      else abort_run("project ready signals do not reach the host");

   task automatic expect_eq(input string name, input word_t exp, input word_t act);
      assert (act === exp)
         else abort_run($sformatf("error %s expected %h actual %h", name, exp, act));
   endtask

   task automatic next_cycle();
      @(posedge ifclk);
      #1;
   endtask

   // whole-address fill pattern
   function automatic word_t data_word(input word_t addr);
      return (addr * 32'h9e37_79b9) ^ 32'h5a3c_c3a5;
   endfunction

   task automatic host_write(input term_addr_t term, input word_t addr, input int n);
      int   i;
      logic ok;
      i          = 0;
      term_addr  = term;
      reg_addr   = addr;
      len        = word_t'(n);
      write_mode = 1'b1;
      while (i < n) begin
         write     = 1'b1;
         reg_datai = wbuf[i];
         @(negedge ifclk);
         ok          = write_rdy;
         last_status = transfer_status;
         next_cycle();
         if (ok)
            i++;
      end
      write      = 1'b0;
      write_mode = 1'b0;
      next_cycle();   // router lets go of the destination
   endtask

   task automatic host_read(input term_addr_t term, input word_t addr, input int n);
      int   i;
      logic ok;
      word_t d;
      i         = 0;
      term_addr = term;
      reg_addr  = addr;
      len       = word_t'(n);
      read_mode = 1'b1;
      while (i < n) begin
         read = 1'b1;
         @(negedge ifclk);
         ok          = read_rdy;
         d           = reg_datao;
         last_status = transfer_status;
         next_cycle();
         if (ok) begin
            rbuf[i] = d;
            i++;
         end
      end
      read      = 1'b0;
      read_mode = 1'b0;
      next_cycle();
   endtask

   task automatic ctrl_write(input word_t addr, input word_t value);
      wbuf[0] = value;
      host_write(TERM_DRAM_CTRL, addr, 1);
   endtask

   task automatic set_burst(input word_t v);
      ctrl_write(CTRL_REG_BURST, v);
      burst_set = (v == 0) ? 1 : ((v > MAX_BURST) ? MAX_BURST : int'(v));
      host_read(TERM_DRAM_CTRL, CTRL_REG_BURST, 1);
      expect_eq($sformatf("burst_clamp_%0d", v), word_t'(burst_set), rbuf[0]);
   endtask

   // write n words, check the write commands, read the words back
   task automatic round_trip(input string name, input word_t base, input int n);
      int ncmd;
      int left;
      ncmd = (n + burst_set - 1) / burst_set;
      for (int k = 0; k < n; k++)
         wbuf[k] = data_word(base + k);
      log_instr.delete();
      log_bl.delete();
      log_addr.delete();
      host_write(TERM_DRAM, base, n);
      while (log_bl.size() < ncmd)
         @(negedge ifclk);
      next_cycle();
      for (int k = 0; k < ncmd; k++) begin
         left = n - k * burst_set;
         expect_eq({name, "_cmd_instr"}, word_t'(MEM_WRITE), word_t'(log_instr[k]));
         expect_eq({name, "_cmd_bl"}, word_t'(((left < burst_set) ? left : burst_set) - 1),
                   word_t'(log_bl[k]));
         expect_eq({name, "_cmd_addr"}, (base + k * burst_set) * 4, word_t'(log_addr[k]));
      end
      host_read(TERM_DRAM, base, n);
      for (int k = 0; k < n; k++)
         expect_eq($sformatf("%s_data_%0d", name, k), data_word(base + k), rbuf[k]);
   endtask

   initial begin
      arst_n         = 1'b0;
      term_addr      = TERM_DUMMY;
      reg_addr       = '0;
      len            = '0;
      read_mode      = 1'b0;
      read           = 1'b0;
      write_mode     = 1'b0;
      write          = 1'b0;
      reg_datai      = '0;
      mem_calib_done = 1'b1;
      stress         = 1'b0;
      no_cal         = 1'b0;
      burst_set      = DEFAULT_BURST;
      repeat (16) @(posedge ifclk);
      #1 arst_n = 1'b1;
      expect_eq("reset_outputs", '0, {mem_cmd_en, mem_wr_en, mem_rd_en, mem_reset,
                pt_read_mode, pt_read, pt_write_mode, pt_write, read_rdy, write_rdy});
      repeat (3) next_cycle();   // calib_done through the synchronizer

      host_read(TERM_DUMMY, 32'h5, 2);
      expect_eq("dummy_odd", DUMMY_PATTERN, rbuf[1]);
      expect_eq("dummy_status", STATUS_OK, last_status);
      host_read(TERM_DUMMY, 32'h6, 2);
      expect_eq("dummy_even", ~DUMMY_PATTERN, rbuf[1]);
      wbuf[0] = 32'h1;
      host_write(TERM_DUMMY, 32'h6, 1);
      expect_eq("dummy_write_status", STATUS_OK, last_status);

      host_read(TERM_DRAM_CTRL, CTRL_REG_BURST, 1);
      expect_eq("burst_after_reset", DEFAULT_BURST, rbuf[0]);
      set_burst(0);
      set_burst(45);
      ctrl_write(CTRL_REG_RESET, 1);
      expect_eq("mem_reset_high", 1, mem_reset);
      host_read(TERM_DRAM_CTRL, CTRL_REG_STATUS, 1);
      expect_eq("status_in_reset", 3, rbuf[0]);
      ctrl_write(CTRL_REG_RESET, 0);
      host_read(TERM_DRAM_CTRL, CTRL_REG_STATUS, 1);
      expect_eq("status_calibrated", 1, rbuf[0]);

      set_burst(4);
      round_trip("burst4", 32'h100, 10);

      stress = 1'b1;
      set_burst(5);
      round_trip("stress", 32'h2000, 37);
      stress = 1'b0;

      mem_calib_done = 1'b0;
      repeat (3) next_cycle();
      no_cal = 1'b1;
      host_read(TERM_DRAM_CTRL, CTRL_REG_STATUS, 1);
      expect_eq("status_uncalibrated", 0, rbuf[0]);
      host_write(TERM_DRAM, 32'h300, 4);
      expect_eq("nocal_write_status", STATUS_NOT_READY, last_status);
      host_read(TERM_DRAM, 32'h300, 4);
      expect_eq("nocal_read_status", STATUS_NOT_READY, last_status);
      for (int k = 0; k < 4; k++)
         expect_eq("nocal_read_data", '0, rbuf[k]);
      no_cal         = 1'b0;
      mem_calib_done = 1'b1;
      repeat (3) next_cycle();

      pt_words = 0;
      host_write(TERM_PROJECT, 32'h77, 3);
      expect_eq("project_write_words", 3, pt_words);
      expect_eq("project_write_status", 16'h0042, last_status);
      host_read(TERM_PROJECT, 32'h77, 3);
      expect_eq("project_read_data", 32'hc0de_0077, rbuf[2]);
      expect_eq("project_read_status", 16'h0042, last_status);

      $display("TEST PASS");
      $finish;
   end

endmodule

/* all.f */
verilog/terminal_pkg.sv
verilog/term_if.sv
verilog/terminal_router.sv
verilog/ctrl_terminal.sv
verilog/dram_terminal.sv
verilog/host_terminal_hub.sv
testbench/mem_port_model.sv
testbench/tb_host_terminal_hub.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = tb_host_terminal_hub
FILELIST  = all.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir
